//--- cu_intra_decoder.f
source/cu_intra_pkg.sv
source/syntax_elem_if.sv
source/intra_mode_sequencer.sv
source/syntax_bin_engine.sv
source/cu_intra_decoder.sv
sim/tb_bin_source.sv
sim/tb_cu_intra_decoder.sv

//--- Makefile
SIM       ?= verilator
SIMFLAGS  ?= --binary --timing --assert -j 0
TOP       ?= tb_cu_intra_decoder
FILELIST  ?= cu_intra_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_cu_intra_decoder.sv
// random CUs of all slice and init flag combinations through a CABAC stand-in
// bins, expected requests and the expected record are built from the binarization rules

`timescale 1ns/1ps

module tb_cu_intra_decoder
    import cu_intra_pkg::*;
();

    localparam int        NUM_CU  = 48;
    localparam int        TIMEOUT = NUM_CU * 40 * 6 + 500;
    localparam bit [31:0] SEED    = 32'hb765_05a9;

    logic                         clk;
    logic                         rst_n;
    logic                         cu_valid;
    logic                         part_nxn;
    logic                         cabac_init_flag;
    logic                         cu_ready;
    logic                         bin_req_valid;
    logic                         bin_bypass;
    logic                         out_valid;
    logic                         bin_req_ready;
    logic                         bin_valid;
    logic                         bin_value;
    logic                         bin_underrun;
    logic                         out_ready = 1'b0;
    slice_type_t                  slice_type;
    logic [CTX_IDX_W-1:0]         bin_ctx_idx;
    logic [NUM_PB-1:0]            prev_flags, exp_prev;
    logic [2*NUM_PB-1:0]          mpm_idx_all, exp_mpm;
    logic [ELEM_VAL_W*NUM_PB-1:0] rem_mode_all, exp_rem;
    logic [2:0]                   chroma_mode, exp_chroma;
    logic [34:0]                  record, exp_record, held_record;
    logic [CTX_IDX_W:0]           exp_req_q[$];
    logic [CTX_IDX_W:0]           held_req;
    logic                         hold_out = 1'b0;
    logic                         hold_req = 1'b0;
    logic                         in_flight = 1'b0;
    int                           mismatches = 0;
    int                           failures = 0;
    int                           out_count = 0;
    int                           cycles = 0;

    assign record     = {prev_flags, mpm_idx_all, rem_mode_all, chroma_mode};
    assign exp_record = {exp_prev, exp_mpm, exp_rem, exp_chroma};

    cu_intra_decoder dut_i (.*);

    tb_bin_source src_i (
        .clk,
        .rst_n,
        .bin_req_valid,
        .bin_req_ready,
        .bin_valid,
        .bin_value,
        .underrun      (bin_underrun)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        mismatches++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        failures++;
    endtask

    // I uses table 0, P and B swap tables 1 and 2 under cabac_init_flag
    function automatic logic [1:0] expected_init(input slice_type_t st, input logic f);
        if (st == SLICE_I) begin
            return 2'd0;
        end
        if (st == SLICE_P) begin
            return f ? 2'd2 : 2'd1;
        end
        return f ? 2'd1 : 2'd2;
    endfunction

    task automatic add_bin(input logic b, input logic byp, input logic [CTX_IDX_W-1:0] ctx);
        src_i.push_bin(b);
        exp_req_q.push_back({byp, ctx});
    endtask

    task automatic build_cu(input int n, output slice_type_t st, output logic f,
                            output logic nxn);
        int                   npb;
        logic [1:0]           it;
        logic [1:0]           mpm;
        logic [4:0]           rem;
        logic [CTX_IDX_W-1:0] ctx_chroma;
        st       = slice_type_t'(2'(n % 3));
        f        = ((n / 3) % 2) == 1;
        nxn      = ($urandom_range(1) == 1);
        npb      = nxn ? NUM_PB : 1;
        it       = expected_init(st, f);
        exp_prev = '0;
        exp_mpm  = '0;
        exp_rem  = '0;
        for (int pb = 0; pb < npb; pb++) begin
            exp_prev[pb] = ($urandom_range(1) == 1);
            add_bin(exp_prev[pb], 1'b0, CTX_PREV_LUMA_BASE + CTX_IDX_W'(it));
        end
        for (int pb = 0; pb < npb; pb++) begin
            if (exp_prev[pb]) begin
                mpm = 2'($urandom_range(2));
                exp_mpm[2*pb +: 2] = mpm;
                // ones, then a closing zero unless the value is 2
                for (int k = 0; k < 2 && k <= int'(mpm); k++) begin
                    add_bin(k < int'(mpm), 1'b1, '0);
                end
            end else begin
                case ($urandom_range(3))
                    0:       rem = 5'd0;
                    1:       rem = 5'd31;
                    default: rem = 5'($urandom_range(31));
                endcase
                exp_rem[ELEM_VAL_W*pb +: ELEM_VAL_W] = rem;
                for (int k = ELEM_VAL_W - 1; k >= 0; k--) begin
                    add_bin(rem[k], 1'b1, '0);
                end
            end
        end
        exp_chroma = 3'($urandom_range(4));
        ctx_chroma = CTX_CHROMA_BASE + CTX_IDX_W'(it);
        if (exp_chroma == CHROMA_DM) begin
            add_bin(1'b0, 1'b0, ctx_chroma);
        end else begin
            add_bin(1'b1, 1'b0, ctx_chroma);
            add_bin(exp_chroma[1], 1'b1, '0);
            add_bin(exp_chroma[0], 1'b1, '0);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom_range(2) != 0);
        end
    end

    // result record and output back-pressure
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_out) begin
                assert (out_valid && !cu_ready && record == held_record)
                    else report_mismatch("result changed while out_ready was low");
            end
            if (out_valid && out_ready) begin
                assert (record == exp_record)
                    else report_mismatch($sformatf("record %h, expected %h",
                                                   record, exp_record));
                out_count <= out_count + 1;
            end
            hold_out    = out_valid && !out_ready;
            held_record = record;
        end
    end

    // bin requests against the expected sequence
    always @(posedge clk) begin
        logic [CTX_IDX_W:0] exp_req;
        if (rst_n) begin
            if (hold_req) begin
                assert (bin_req_valid && {bin_bypass, bin_ctx_idx} == held_req)
                    else report_mismatch("bin request changed while stalled");
            end
            assert (!(in_flight && bin_req_valid))
                else report_failure("new bin request before the previous bin returned");
            if (bin_valid) begin
                in_flight = 1'b0;
            end
            if (bin_req_valid && bin_req_ready) begin
                if (exp_req_q.size() == 0) begin
                    report_failure("bin request with no bin left to decode");
                end else begin
                    exp_req = exp_req_q.pop_front();
                    assert ({bin_bypass, bin_ctx_idx} == exp_req)
                        else report_mismatch($sformatf("request bypass/ctx %h, expected %h",
                                                       {bin_bypass, bin_ctx_idx}, exp_req));
                end
                in_flight = 1'b1;
            end
            hold_req = bin_req_valid && !bin_req_ready;
            held_req = {bin_bypass, bin_ctx_idx};
            assert (!bin_underrun) else report_failure("bin source ran out of bins");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        slice_type_t st;
        logic        f;
        logic        nxn;
        void'($urandom(SEED));
        rst_n           <= 1'b0;
        cu_valid        <= 1'b0;
        part_nxn        <= 1'b0;
        slice_type      <= SLICE_I;
        cabac_init_flag <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (cu_ready && !bin_req_valid && !out_valid)
            else report_mismatch("cu_ready, bin_req_valid or out_valid wrong after reset");
        for (int n = 0; n < NUM_CU; n++) begin
            build_cu(n, st, f, nxn);
            cu_valid        <= 1'b1;
            part_nxn        <= nxn;
            slice_type      <= st;
            cabac_init_flag <= f;
            do @(posedge clk); while (!cu_ready);
            cu_valid <= 1'b0;
            while (out_count <= n) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        assert (exp_req_q.size() == 0)
            else report_failure("expected bin requests never arrived");
        $display("%0d CUs checked, %0d mismatches, %0d other errors",
                 out_count, mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/tb_bin_source.sv
// CABAC bin decoder stand-in, answers each accepted request from a queue of bins
// bin_req_ready drops at random, a bin returns 1 to 4 cycles after acceptance

`timescale 1ns/1ps

module tb_bin_source (
    input  logic clk,
    input  logic rst_n,
    input  logic bin_req_valid,
    output logic bin_req_ready,
    output logic bin_valid,
    output logic bin_value,
    output logic underrun
);

    logic       bin_q[$];
    logic       ready_q = 1'b0;
    logic       valid_q = 1'b0;
    logic       value_q = 1'b0;
    logic       underrun_q = 1'b0;
    logic       busy = 1'b0;
    logic [1:0] wait_cnt = 2'd0;

    assign bin_req_ready = ready_q;
    assign bin_valid     = valid_q;
    assign bin_value     = value_q;
    assign underrun      = underrun_q;

    task automatic push_bin(input logic b);
        bin_q.push_back(b);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ready_q    <= 1'b0;
            valid_q    <= 1'b0;
            underrun_q <= 1'b0;
            busy       <= 1'b0;
            wait_cnt   <= 2'd0;
        end else begin
            valid_q    <= 1'b0;
            underrun_q <= 1'b0;
            // ready about three cycles in four
            ready_q    <= ($urandom_range(3) != 0);
            if (bin_req_valid && ready_q) begin
                busy     <= 1'b1;
                wait_cnt <= 2'($urandom_range(3));
            end else if (busy) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    busy    <= 1'b0;
                    valid_q <= 1'b1;
                    if (bin_q.size() > 0) begin
                        value_q <= bin_q.pop_front();
                    end else begin
                        underrun_q <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- source/cu_intra_decoder.sv
// intra prediction syntax decoder for one HEVC CU, fed by an external CABAC bin decoder
// part_nxn, slice_type and cabac_init_flag are sampled when cu_valid meets cu_ready
// for 2Nx2N only entry 0 of the record is meaningful, the others read zero

`timescale 1ns/1ps

module cu_intra_decoder
    import cu_intra_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cu_valid,
    output logic                         cu_ready,
    input  logic                         part_nxn,
    input  slice_type_t                  slice_type,
    input  logic                         cabac_init_flag,
    output logic                         bin_req_valid,
    input  logic                         bin_req_ready,
    output logic [CTX_IDX_W-1:0]         bin_ctx_idx,
    output logic                         bin_bypass,
    input  logic                         bin_valid,
    input  logic                         bin_value,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [NUM_PB-1:0]            prev_flags,
    output logic [2*NUM_PB-1:0]          mpm_idx_all,
    output logic [ELEM_VAL_W*NUM_PB-1:0] rem_mode_all,
    output logic [2:0]                   chroma_mode
);

    syntax_elem_if elem_if ();

    intra_mode_sequencer seq_i (
        .clk,
        .rst_n,
        .cu_valid,
        .cu_ready,
        .part_nxn,
        .slice_type,
        .cabac_init_flag,
        .elem         (elem_if),
        .out_valid,
        .out_ready,
        .prev_flags,
        .mpm_idx_all,
        .rem_mode_all,
        .chroma_mode
    );

    syntax_bin_engine eng_i (
        .clk,
        .rst_n,
        .elem          (elem_if),
        .bin_req_valid,
        .bin_req_ready,
        .bin_ctx_idx,
        .bin_bypass,
        .bin_valid,
        .bin_value
    );

endmodule

//--- source/syntax_bin_engine.sv
// decodes one syntax element per handshake by requesting bins one at a time
// only one bin request is outstanding; the next waits for bin_valid

`timescale 1ns/1ps

module syntax_bin_engine
    import cu_intra_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    syntax_elem_if.eng           elem,
    output logic                 bin_req_valid,
    input  logic                 bin_req_ready,
    output logic [CTX_IDX_W-1:0] bin_ctx_idx,
    output logic                 bin_bypass,
    input  logic                 bin_valid,
    input  logic                 bin_value
);

    typedef enum logic [1:0] {
        E_IDLE,
        E_REQ,
        E_WAIT,
        E_DONE
    } eng_state_t;

    eng_state_t            state;
    elem_kind_t            kind_q;
    init_type_t            init_q;
    logic [2:0]            bin_cnt;
    logic [ELEM_VAL_W-1:0] val_q;
    logic [ELEM_VAL_W-1:0] val_next;
    logic                  elem_end;

    assign elem.elem_ready = (state == E_IDLE);
    assign elem.done_valid = (state == E_DONE);
    assign elem.done_value = val_q;
    assign bin_req_valid   = (state == E_REQ);

    // only the prev flag and the first chroma bin are context coded
    always_comb begin
        bin_bypass  = 1'b1;
        bin_ctx_idx = '0;
        if (kind_q == ELEM_PREV_FLAG) begin
            bin_bypass  = 1'b0;
            bin_ctx_idx = CTX_PREV_LUMA_BASE + CTX_IDX_W'(init_q);
        end else if (kind_q == ELEM_CHROMA && bin_cnt == 3'd0) begin
            bin_bypass  = 1'b0;
            bin_ctx_idx = CTX_CHROMA_BASE + CTX_IDX_W'(init_q);
        end
    end

    // binarization, bin_cnt holds the bins already received
    always_comb begin
        val_next = {val_q[ELEM_VAL_W-2:0], bin_value};
        elem_end = 1'b1;
        case (kind_q)
            ELEM_MPM_IDX: begin
                // truncated unary, cMax 2
                val_next = val_q + ELEM_VAL_W'(bin_value);
                elem_end = !bin_value || bin_cnt == 3'd1;
            end
            ELEM_REM_MODE: begin
                elem_end = (bin_cnt == 3'd4);
            end
            ELEM_CHROMA: begin
                if (bin_cnt == 3'd0 && !bin_value) begin
                    val_next = ELEM_VAL_W'(CHROMA_DM);
                end else begin
                    // leading 1 falls off after the two bypass bins
                    val_next      = '0;
                    val_next[1:0] = {val_q[0], bin_value};
                end
                elem_end = (bin_cnt == 3'd0 && !bin_value) || bin_cnt == 3'd2;
            end
            default: elem_end = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= E_IDLE;
            kind_q  <= ELEM_PREV_FLAG;
            bin_cnt <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (elem.elem_valid) begin
                        state   <= E_REQ;
                        kind_q  <= elem.elem_kind;
                        bin_cnt <= '0;
                    end
                end
                E_REQ: begin
                    if (bin_req_ready) begin
                        state <= E_WAIT;
                    end
                end
                E_WAIT: begin
                    if (bin_valid) begin
                        bin_cnt <= bin_cnt + 3'd1;
                        state   <= elem_end ? E_DONE : E_REQ;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_IDLE && elem.elem_valid) begin
            init_q <= elem.init_type;
            val_q  <= '0;
        end else if (state == E_WAIT && bin_valid) begin
            val_q <= val_next;
        end
    end

endmodule

//--- source/intra_mode_sequencer.sv
// CU level FSM: prev flags, then mpm_idx or rem mode per block, then chroma
// the record is cleared at acceptance and stays stable while out_valid waits on out_ready

`timescale 1ns/1ps

module intra_mode_sequencer
    import cu_intra_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cu_valid,
    output logic                         cu_ready,
    input  logic                         part_nxn,
    input  slice_type_t                  slice_type,
    input  logic                         cabac_init_flag,
    syntax_elem_if.seq                   elem,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [NUM_PB-1:0]            prev_flags,
    output logic [2*NUM_PB-1:0]          mpm_idx_all,
    output logic [ELEM_VAL_W*NUM_PB-1:0] rem_mode_all,
    output logic [2:0]                   chroma_mode
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ELEM,
        S_WAIT,
        S_OUT
    } seq_state_t;

    seq_state_t          state;
    elem_kind_t          cur_kind;
    logic [PB_IDX_W-1:0] pb_idx;
    logic [PB_IDX_W-1:0] next_pb;
    logic [PB_IDX_W-1:0] luma_pb;
    logic                nxn_q;
    init_type_t          init_q;
    logic [NUM_PB-1:0]   flags_upd;
    logic                last_pb;
    elem_kind_t          luma_kind;

    assign cu_ready        = (state == S_IDLE);
    assign out_valid       = (state == S_OUT);
    assign elem.elem_valid = (state == S_ELEM);
    assign elem.elem_kind  = cur_kind;
    assign elem.init_type  = init_q;

    // flags including the one finishing this cycle
    always_comb begin
        flags_upd = prev_flags;
        if (cur_kind == ELEM_PREV_FLAG) begin
            flags_upd[pb_idx] = elem.done_value[0];
        end
    end

    assign last_pb = !nxn_q || (pb_idx == PB_IDX_W'(NUM_PB - 1));
    assign next_pb = pb_idx + PB_IDX_W'(1);

    // after the last flag the luma walk restarts at block 0
    assign luma_pb   = (cur_kind == ELEM_PREV_FLAG) ? '0 : next_pb;
    assign luma_kind = flags_upd[luma_pb] ? ELEM_MPM_IDX : ELEM_REM_MODE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            cur_kind <= ELEM_PREV_FLAG;
            pb_idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cu_valid) begin
                        state    <= S_ELEM;
                        cur_kind <= ELEM_PREV_FLAG;
                        pb_idx   <= '0;
                    end
                end
                S_ELEM: begin
                    if (elem.elem_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (elem.done_valid) begin
                        state <= S_ELEM;
                        case (cur_kind)
                            ELEM_PREV_FLAG: begin
                                pb_idx <= last_pb ? '0 : next_pb;
                                if (last_pb) begin
                                    cur_kind <= luma_kind;
                                end
                            end
                            ELEM_MPM_IDX, ELEM_REM_MODE: begin
                                if (last_pb) begin
                                    cur_kind <= ELEM_CHROMA;
                                end else begin
                                    pb_idx   <= next_pb;
                                    cur_kind <= luma_kind;
                                end
                            end
                            default: state <= S_OUT;
                        endcase
                    end
                end
                default: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // command fields and mode record
    always_ff @(posedge clk) begin
        if (cu_valid && cu_ready) begin
            nxn_q        <= part_nxn;
            init_q       <= init_type_of(slice_type, cabac_init_flag);
            prev_flags   <= '0;
            mpm_idx_all  <= '0;
            rem_mode_all <= '0;
            chroma_mode  <= '0;
        end else if (state == S_WAIT && elem.done_valid) begin
            case (cur_kind)
                ELEM_PREV_FLAG: prev_flags <= flags_upd;
                ELEM_MPM_IDX:   mpm_idx_all[{pb_idx, 1'b0} +: 2] <= elem.done_value[1:0];
                ELEM_REM_MODE:  rem_mode_all[pb_idx*ELEM_VAL_W +: ELEM_VAL_W] <= elem.done_value;
                default:        chroma_mode <= elem.done_value[2:0];
            endcase
        end
    end

endmodule

//--- source/syntax_elem_if.sv
// element handshake between the sequencer and the bin engine
// one element in flight; done_valid is a single-cycle pulse

`timescale 1ns/1ps

interface syntax_elem_if
    import cu_intra_pkg::*;
();

    logic                  elem_valid;
    elem_kind_t            elem_kind;
    init_type_t            init_type;
    logic                  elem_ready;
    logic                  done_valid;
    logic [ELEM_VAL_W-1:0] done_value;

    modport seq (
        output elem_valid,
        output elem_kind,
        output init_type,
        input  elem_ready,
        input  done_valid,
        input  done_value
    );

    modport eng (
        input  elem_valid,
        input  elem_kind,
        input  init_type,
        output elem_ready,
        output done_valid,
        output done_value
    );

endinterface

//--- source/cu_intra_pkg.sv
// shared widths, element kinds and context bases for the intra CU decoder
// context indices are placeholders for one flat context memory, base plus init type
// chroma is decoded once per CU, 4:2:0 only

package cu_intra_pkg;

    localparam int CTX_IDX_W  = 10;
    localparam int ELEM_VAL_W = 5;
    localparam int NUM_PB     = 4;
    localparam int PB_IDX_W   = $clog2(NUM_PB);

    // slice_type as coded in the slice header
    typedef enum logic [1:0] {
        SLICE_B = 2'd0,
        SLICE_P = 2'd1,
        SLICE_I = 2'd2
    } slice_type_t;

    // cabac init type, 0 to 2
    typedef logic [1:0] init_type_t;

    typedef enum logic [1:0] {
        ELEM_PREV_FLAG = 2'd0,
        ELEM_MPM_IDX   = 2'd1,
        ELEM_REM_MODE  = 2'd2,
        ELEM_CHROMA    = 2'd3
    } elem_kind_t;

    // three contexts each, one per init type
    localparam logic [CTX_IDX_W-1:0] CTX_PREV_LUMA_BASE = 10'd60;
    localparam logic [CTX_IDX_W-1:0] CTX_CHROMA_BASE    = 10'd63;

    // derived chroma mode
    localparam logic [2:0] CHROMA_DM = 3'd4;

    // P and B swap their tables when cabac_init_flag is set
    function automatic init_type_t init_type_of(slice_type_t st, logic init_flag);
        init_type_t it;
        case (st)
            SLICE_I: it = 2'd0;
            SLICE_P: it = init_flag ? 2'd2 : 2'd1;
            default: it = init_flag ? 2'd1 : 2'd2;
        endcase
        return it;
    endfunction

endpackage
